//--- rtl/spi_cfg.svh
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

//////////////////////////////////////////////////
// bus format

`define SPI_DATA_W   32 // widest word on the bus
`define SPI_DELAY_W  8  // setup and hold delays, in gclk cycles

//////////////////////////////////////////////////
// sck rates

// gclk cycles per sck half-period
`define SPI_HALF_DIV16   8
`define SPI_HALF_DIV32   16
`define SPI_HALF_DIV64   32
`define SPI_HALF_DIV128  64

`define SPI_HALF_W   7  // holds up to 64
`define SPI_EDGE_W   7  // 2 x 32 edges for the longest word

`endif

//--- rtl/spi_pkg.sv
`include "spi_cfg.svh"

package spi_pkg;

    //////////////////////////////////////////////////
    // plain vectors

    typedef logic [`SPI_DATA_W-1:0]  spi_data_t;     // word on mosi or miso
    typedef logic [`SPI_DELAY_W-1:0] spi_delay_t;    // gclk cycles
    typedef logic [`SPI_EDGE_W-1:0]  spi_edge_cnt_t; // sck edges left in a frame
    typedef logic [`SPI_HALF_W-1:0]  spi_half_cnt_t; // gclk cycles in a half-period

    // bit 1 is cpol (idle level), bit 0 is cpha (1 = sample on trailing edge)
    typedef logic [1:0] spi_mode_t;

    // 0: 1/128, 1: 1/64, 2: 1/32, 3: 1/16 of gclk
    typedef logic [1:0] spi_rate_t;

    // 0: 32 bits, 1: 16, 2: 8, 3: 4
    typedef logic [1:0] spi_len_t;

    //////////////////////////////////////////////////
    // structs

    // one request from the host
    typedef struct packed {
        spi_mode_t  mode;
        spi_rate_t  rate;
        spi_len_t   len;
        spi_delay_t setup; // cs fall to first sck toggle
        spi_delay_t hold;  // last sck toggle to cs rise
        spi_data_t  tx;
    } spi_cmd_t;

    // strobes, high in the gclk cycle before sck toggles
    typedef struct packed {
        logic lead;  // sck leaves the idle level
        logic trail; // sck returns to the idle level
    } sck_edge_t;

    // frame sequencer
    typedef enum logic [1:0] {
        S_IDLE,
        S_SETUP,
        S_SHIFT,
        S_HOLD
    } seq_state_t;

endpackage

//--- rtl/spi_req_port.sv
`timescale 1ns/10ps

module spi_req_port (
    input  logic                gclk_i,
    input  logic                nrst_i,
    // host side
    input  logic                req_i,
    input  spi_pkg::spi_cmd_t   cmd_i,
    output logic                ack_o,
    output spi_pkg::spi_data_t  rx_data_o,
    // core side
    output logic                start_o,
    output spi_pkg::spi_cmd_t   cmd_o,
    input  logic                frame_done_i,
    input  spi_pkg::spi_data_t  rx_word_i
);

    import spi_pkg::*;

    typedef enum logic [1:0] {
        H_IDLE, // waiting for req
        H_BUSY, // frame on the bus
        H_ACK   // ack held until req drops
    } hs_state_t;

    hs_state_t hs_q;
    logic      req_q;   // req as seen by the handshake fsm
    logic      start_q;
    logic      ack_q;
    spi_cmd_t  cmd_q;   // holds the sck idle level between frames
    spi_data_t rx_q;

    always_ff @(posedge gclk_i) begin
        if (!nrst_i) begin
            hs_q    <= H_IDLE;
            req_q   <= 1'b0;
            start_q <= 1'b0;
            ack_q   <= 1'b0;
            cmd_q   <= '0;
        end else begin
            req_q   <= req_i;
            start_q <= 1'b0;
            case (hs_q)
                H_IDLE: if (req_q) begin
                    cmd_q   <= cmd_i;    // one latch per request
                    start_q <= 1'b1;
                    hs_q    <= H_BUSY;
                end
                H_BUSY: if (frame_done_i) begin
                    ack_q <= 1'b1;
                    hs_q  <= H_ACK;
                end
                H_ACK: if (!req_q) begin
                    ack_q <= 1'b0;
                    hs_q  <= H_IDLE;
                end
                default: hs_q <= H_IDLE;
            endcase
        end
    end

    // received word, stable for as long as ack is high
    always_ff @(posedge gclk_i) begin
        if (hs_q == H_BUSY && frame_done_i) begin
            rx_q <= rx_word_i;
        end
    end

    assign start_o   = start_q;
    assign cmd_o     = cmd_q;
    assign ack_o     = ack_q;
    assign rx_data_o = rx_q;

    // host must still hold req when the frame completes
    a_ack_needs_req: assert property (@(posedge gclk_i) disable iff (!nrst_i)
        $rose(ack_o) |-> $past(req_i));

endmodule

//--- rtl/spi_sck_gen.sv
`timescale 1ns/10ps
`include "spi_cfg.svh"

module spi_sck_gen (
    input  logic                gclk_i,
    input  logic                nrst_i,
    input  spi_pkg::spi_mode_t  mode_i,
    input  spi_pkg::spi_rate_t  rate_i,
    input  logic                run_i,
    output logic                sck_o,
    output spi_pkg::sck_edge_t  edge_o
);

    import spi_pkg::*;

    spi_half_cnt_t half;     // half-period for the selected rate
    spi_half_cnt_t last_cnt;
    spi_half_cnt_t cnt_q;
    logic          sck_q;
    logic          fire;     // sck toggles at the next edge

    //////////////////////////////////////////////////
    // half-period select

    always_comb begin
        case (rate_i)
            2'd0:    half = spi_half_cnt_t'(`SPI_HALF_DIV128);
            2'd1:    half = spi_half_cnt_t'(`SPI_HALF_DIV64);
            2'd2:    half = spi_half_cnt_t'(`SPI_HALF_DIV32);
            default: half = spi_half_cnt_t'(`SPI_HALF_DIV16);
        endcase
    end

    assign last_cnt = half - 1'b1;
    assign fire     = run_i && (cnt_q == last_cnt);

    //////////////////////////////////////////////////
    // divider and sck level

    always_ff @(posedge gclk_i) begin
        if (!nrst_i) begin
            cnt_q <= '0;
            sck_q <= 1'b0;
        end else if (!run_i) begin
            cnt_q <= last_cnt;   // first toggle comes straight after run rises
            sck_q <= mode_i[1];  // park at cpol
        end else if (fire) begin
            cnt_q <= '0;
            sck_q <= ~sck_q;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // leading edge moves sck away from cpol
    assign edge_o.lead  = fire && (sck_q == mode_i[1]);
    assign edge_o.trail = fire && (sck_q != mode_i[1]);
    assign sck_o        = sck_q;

    // rate and polarity hold still while sck runs
    a_cfg_stable_while_run: assert property (@(posedge gclk_i) disable iff (!nrst_i)
        (run_i && $past(run_i)) |-> ($stable(mode_i) && $stable(rate_i)));

endmodule

//--- rtl/spi_sequencer.sv
`timescale 1ns/10ps
`include "spi_cfg.svh"

module spi_sequencer (
    input  logic                gclk_i,
    input  logic                nrst_i,
    input  logic                start_i,
    input  spi_pkg::spi_cmd_t   cmd_i,
    input  spi_pkg::sck_edge_t  edge_i,
    output logic                cs_n_o,
    output logic                sck_run_o,
    output logic                load_o,
    output logic                frame_done_o
);

    import spi_pkg::*;

    seq_state_t    state_q;
    spi_delay_t    dly_q;    // shared by setup and hold
    spi_edge_cnt_t edge_q;   // sck edges still to come
    spi_edge_cnt_t n_edges;
    logic          cs_n_q;
    logic          done_q;
    logic          strobe;

    // counter runs down to 0 and a delay of 0 acts as 1
    function automatic spi_delay_t dly_load(input spi_delay_t d);
        spi_delay_t v;
        v = (d == '0) ? '0 : d - 1'b1;
        return v;
    endfunction

    assign n_edges = spi_edge_cnt_t'((2 * `SPI_DATA_W) >> cmd_i.len); // 64, 32, 16 or 8
    assign strobe  = edge_i.lead | edge_i.trail;

    //////////////////////////////////////////////////
    // frame fsm

    always_ff @(posedge gclk_i) begin
        if (!nrst_i) begin
            state_q <= S_IDLE;
            dly_q   <= '0;
            edge_q  <= '0;
            cs_n_q  <= 1'b1;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (strobe) begin
                edge_q <= edge_q - 1'b1;
            end
            case (state_q)
                S_IDLE: if (start_i) begin
                    cs_n_q  <= 1'b0;
                    dly_q   <= dly_load(cmd_i.setup);
                    edge_q  <= n_edges;
                    state_q <= S_SETUP;
                end
                S_SETUP: begin
                    if (dly_q == '0) begin
                        state_q <= S_SHIFT;  // first toggle lands on this edge
                    end else begin
                        dly_q <= dly_q - 1'b1;
                    end
                end
                S_SHIFT: if (strobe && edge_q == spi_edge_cnt_t'(1)) begin
                    dly_q   <= dly_load(cmd_i.hold);
                    state_q <= S_HOLD;
                end
                S_HOLD: begin
                    if (dly_q == '0) begin
                        cs_n_q  <= 1'b1;
                        done_q  <= 1'b1;
                        state_q <= S_IDLE;
                    end else begin
                        dly_q <= dly_q - 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // sck starts in the last setup cycle so the toggle meets the setup count
    assign sck_run_o    = (state_q == S_SETUP && dly_q == '0) || (state_q == S_SHIFT);
    assign load_o       = start_i && (state_q == S_IDLE); // shifter loads as cs falls
    assign cs_n_o       = cs_n_q;
    assign frame_done_o = done_q;

    // sck must stay quiet outside the cs window
    a_no_edge_cs_high: assert property (@(posedge gclk_i) disable iff (!nrst_i)
        (edge_i.lead || edge_i.trail) |-> !cs_n_o);

endmodule

//--- rtl/spi_shifter.sv
`timescale 1ns/10ps
`include "spi_cfg.svh"

module spi_shifter (
    input  logic                gclk_i,
    input  logic                nrst_i,
    input  logic                load_i,
    input  spi_pkg::spi_mode_t  mode_i,
    input  spi_pkg::spi_len_t   len_i,
    input  spi_pkg::spi_data_t  tx_i,
    input  spi_pkg::sck_edge_t  edge_i,
    input  logic                miso_i,
    output logic                mosi_o,
    output spi_pkg::spi_data_t  rx_word_o
);

    import spi_pkg::*;

    spi_data_t tx_aligned; // active bits moved to the top
    spi_data_t tx_sr;
    spi_data_t rx_sr;
    logic      mosi_q;
    logic      launch;
    logic      sample;

    assign tx_aligned = tx_i << (`SPI_DATA_W - (`SPI_DATA_W >> len_i));

    // cpha 0 launches on trail, cpha 1 on lead
    assign launch = mode_i[0] ? edge_i.lead  : edge_i.trail;
    assign sample = mode_i[0] ? edge_i.trail : edge_i.lead;

    //////////////////////////////////////////////////
    // mosi line

    always_ff @(posedge gclk_i) begin
        if (!nrst_i) begin
            mosi_q <= 1'b0;
        end else if (load_i) begin
            // cpha 0 needs the msb out before the first edge
            mosi_q <= mode_i[0] ? 1'b0 : tx_aligned[`SPI_DATA_W-1];
        end else if (launch) begin
            mosi_q <= tx_sr[`SPI_DATA_W-1];
        end
    end

    //////////////////////////////////////////////////
    // shift registers

    always_ff @(posedge gclk_i) begin
        if (load_i) begin
            if (mode_i[0]) begin
                tx_sr <= tx_aligned;
            end else begin
                tx_sr <= {tx_aligned[`SPI_DATA_W-2:0], 1'b0}; // msb already on the line
            end
            rx_sr <= '0;
        end else begin
            if (launch) begin
                tx_sr <= {tx_sr[`SPI_DATA_W-2:0], 1'b0};
            end
            if (sample) begin
                rx_sr <= {rx_sr[`SPI_DATA_W-2:0], miso_i}; // fills from the lsb
            end
        end
    end

    assign mosi_o    = mosi_q;
    assign rx_word_o = rx_sr;

endmodule

//--- rtl/spi_master_top.sv
`timescale 1ns/10ps

module spi_master_top (
    input  logic                gclk_i,
    input  logic                nrst_i,
    input  logic                req_i,
    input  spi_pkg::spi_cmd_t   cmd_i,
    output logic                ack_o,
    output spi_pkg::spi_data_t  rx_data_o,
    input  logic                miso_i,
    output logic                mosi_o,
    output logic                sck_o,
    output logic                cs_n_o
);

    import spi_pkg::*;

    logic      start;
    logic      frame_done;
    logic      load;
    logic      sck_run;
    spi_cmd_t  cmd;        // latched request
    spi_data_t rx_word;
    sck_edge_t sck_edge;

    //////////////////////////////////////////////////
    // host handshake

    spi_req_port u_req_port (
        .gclk_i       (gclk_i),
        .nrst_i       (nrst_i),
        .req_i        (req_i),
        .cmd_i        (cmd_i),
        .ack_o        (ack_o),
        .rx_data_o    (rx_data_o),
        .start_o      (start),
        .cmd_o        (cmd),
        .frame_done_i (frame_done),
        .rx_word_i    (rx_word)
    );

    //////////////////////////////////////////////////
    // bus side

    spi_sck_gen u_sck_gen (
        .gclk_i (gclk_i),
        .nrst_i (nrst_i),
        .mode_i (cmd.mode),
        .rate_i (cmd.rate),
        .run_i  (sck_run),
        .sck_o  (sck_o),
        .edge_o (sck_edge)
    );

    spi_sequencer u_sequencer (
        .gclk_i       (gclk_i),
        .nrst_i       (nrst_i),
        .start_i      (start),
        .cmd_i        (cmd),
        .edge_i       (sck_edge),
        .cs_n_o       (cs_n_o),
        .sck_run_o    (sck_run),
        .load_o       (load),
        .frame_done_o (frame_done)
    );

    spi_shifter u_shifter (
        .gclk_i    (gclk_i),
        .nrst_i    (nrst_i),
        .load_i    (load),
        .mode_i    (cmd.mode),
        .len_i     (cmd.len),
        .tx_i      (cmd.tx),
        .edge_i    (sck_edge),
        .miso_i    (miso_i),
        .mosi_o    (mosi_o),
        .rx_word_o (rx_word)
    );

endmodule

//--- verif/spi_slave_model.sv
`timescale 1ns/10ps
`include "spi_cfg.svh"

module spi_slave_model (
    input  logic                   gclk_i,
    input  spi_pkg::spi_mode_t     mode_i,
    input  spi_pkg::spi_len_t      len_i,
    input  spi_pkg::spi_data_t     reply_i,
    input  logic                   cs_n_i,
    input  logic                   sck_i,
    input  logic                   mosi_i,
    output logic                   miso_o,
    output spi_pkg::spi_data_t     mosi_word_o,
    output spi_pkg::spi_delay_t    setup_o,
    output spi_pkg::spi_delay_t    hold_o,
    output spi_pkg::spi_half_cnt_t half_o,
    output spi_pkg::spi_delay_t    toggles_o,
    output logic                   half_err_o
);

    import spi_pkg::*;

    spi_data_t     tx_sr = '0;
    spi_data_t     rx_sr = '0;
    logic          in_frame = 1'b0;
    logic          sck_q = 1'b0;    // sck as seen at the last gclk edge
    logic          miso_q = 1'b0;
    logic          half_err = 1'b0;
    spi_data_t     mosi_word = '0;
    spi_delay_t    setup_q = '0;
    spi_delay_t    hold_q = '0;
    spi_delay_t    toggles_q = '0;
    spi_half_cnt_t half_q = '0;
    int            cyc = 0;
    int            t_fall = 0;
    int            t_first = 0;
    int            t_last = 0;
    int            n_tog = 0;
    int            bits = 0;

    // bus changes land one gclk edge before they are seen here, so a toggle
    // seen at count cyc happened at cyc - 1
    always @(posedge gclk_i or negedge cs_n_i) begin
        if (!cs_n_i && !in_frame) begin
            in_frame = 1'b1;
            bits     = `SPI_DATA_W >> len_i;
            tx_sr    = reply_i << (`SPI_DATA_W - bits); // msb first
            rx_sr    = '0;
            sck_q    = mode_i[1];  // sck parks at cpol as cs falls
            n_tog    = 0;
            half_err = 1'b0;
            t_fall   = cyc;
            if (mode_i[0]) begin
                miso_q = 1'b0;
            end else begin
                miso_q = tx_sr[`SPI_DATA_W-1]; // cpha 0 shows the first bit at once
                tx_sr  = tx_sr << 1;
            end
        end else begin
            cyc = cyc + 1;
            if (in_frame && cs_n_i) begin
                in_frame  = 1'b0;
                setup_q   = spi_delay_t'(t_first - t_fall);
                hold_q    = spi_delay_t'(cyc - 1 - t_last);
                toggles_q = spi_delay_t'(n_tog);
                mosi_word = rx_sr;
            end else if (in_frame && sck_i != sck_q) begin
                n_tog = n_tog + 1;
                if (n_tog == 1) begin
                    t_first = cyc - 1;
                end else if (n_tog == 2) begin
                    half_q = spi_half_cnt_t'(cyc - 1 - t_last);
                end else if (spi_half_cnt_t'(cyc - 1 - t_last) != half_q) begin
                    half_err = 1'b1;
                end
                t_last = cyc - 1;
                // sample edge is lead for cpha 0, trail for cpha 1
                if ((sck_i != mode_i[1]) != mode_i[0]) begin
                    rx_sr = {rx_sr[`SPI_DATA_W-2:0], mosi_i};
                end else begin
                    miso_q = tx_sr[`SPI_DATA_W-1];
                    tx_sr  = tx_sr << 1;
                end
            end
            sck_q = sck_i;
        end
    end

    assign miso_o      = miso_q;
    assign mosi_word_o = mosi_word;
    assign setup_o     = setup_q;
    assign hold_o      = hold_q;
    assign half_o      = half_q;
    assign toggles_o   = toggles_q;
    assign half_err_o  = half_err;

endmodule

//--- verif/tb_spi_master.sv
`timescale 1ns/10ps
`include "spi_cfg.svh"

module tb_spi_master;

    import spi_pkg::*;

    localparam int MAX_CASES = 32;

    logic          gclk;
    logic          nrst;
    logic          req;
    spi_cmd_t      cmd;
    logic          ack;
    spi_data_t     rx_data;
    logic          miso;
    logic          mosi;
    logic          sck;
    logic          cs_n;
    spi_data_t     reply;         // word the slave sends back
    spi_data_t     slave_mosi;
    spi_delay_t    slave_setup;
    spi_delay_t    slave_hold;
    spi_delay_t    slave_toggles;
    spi_half_cnt_t slave_half;
    logic          slave_half_err;

    spi_cmd_t      case_cmd   [MAX_CASES];
    spi_data_t     case_reply [MAX_CASES];
    spi_data_t     case_rx    [MAX_CASES];
    spi_data_t     case_mosi  [MAX_CASES];

    int            n_cases;
    int            errors;
    int            case_errs;
    int            passed;
    int            failed;
    int            cyc_cnt;
    int            cyc_limit;
    int            k;
    logic          timer_on;
    integer        seed;

    spi_master_top dut (
        .gclk_i    (gclk),
        .nrst_i    (nrst),
        .req_i     (req),
        .cmd_i     (cmd),
        .ack_o     (ack),
        .rx_data_o (rx_data),
        .miso_i    (miso),
        .mosi_o    (mosi),
        .sck_o     (sck),
        .cs_n_o    (cs_n)
    );

    spi_slave_model u_slave (
        .gclk_i      (gclk),
        .mode_i      (cmd.mode),
        .len_i       (cmd.len),
        .reply_i     (reply),
        .cs_n_i      (cs_n),
        .sck_i       (sck),
        .mosi_i      (mosi),
        .miso_o      (miso),
        .mosi_word_o (slave_mosi),
        .setup_o     (slave_setup),
        .hold_o      (slave_hold),
        .half_o      (slave_half),
        .toggles_o   (slave_toggles),
        .half_err_o  (slave_half_err)
    );

    initial gclk = 1'b0;
    always #4 gclk = ~gclk;

    always @(posedge gclk) begin
        if (timer_on) begin
            cyc_cnt = cyc_cnt + 1;
            if (cyc_cnt > cyc_limit) begin
                $display("Timeout: the cases did not finish within %0d cycles", cyc_limit);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    //////////////////////////////////////////////////
    // rules of the bus format

    function automatic int word_bits(input spi_len_t len);
        case (len)
            2'd0:    return 32;
            2'd1:    return 16;
            2'd2:    return 8;
            default: return 4;
        endcase
    endfunction

    function automatic int half_cycles(input spi_rate_t rate);
        case (rate)
            2'd0:    return 64;
            2'd1:    return 32;
            2'd2:    return 16;
            default: return 8;
        endcase
    endfunction

    // a delay of 0 still gives one cycle
    function automatic spi_delay_t at_least_one(input spi_delay_t d);
        return (d == '0) ? spi_delay_t'(1) : d;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks

    task automatic compare_word(input string what, input spi_data_t got, input spi_data_t exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            case_errs++;
        end
    endtask

    task automatic verify_count(input string what, input spi_delay_t got, input spi_delay_t exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %0d cycles, expected %0d", $time, what, got, exp);
            errors++;
            case_errs++;
        end
    endtask

    task automatic expect_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
            case_errs++;
        end
    endtask

    //////////////////////////////////////////////////
    // case file and frame driver

    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] fm, fr, fl, fs, fh, ft, fy, fx, fo;
        fd = $fopen("verif/spi_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file verif/spi_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "/") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            fm, fr, fl, fs, fh, ft, fy, fx, fo);
                if (n == 9) begin
                    case_cmd[n_cases].mode  = spi_mode_t'(fm);
                    case_cmd[n_cases].rate  = spi_rate_t'(fr);
                    case_cmd[n_cases].len   = spi_len_t'(fl);
                    case_cmd[n_cases].setup = spi_delay_t'(fs);
                    case_cmd[n_cases].hold  = spi_delay_t'(fh);
                    case_cmd[n_cases].tx    = ft;
                    case_reply[n_cases]     = fy;
                    case_rx[n_cases]        = fx;
                    case_mosi[n_cases]      = fo;
                    n_cases++;
                end
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            $display("The case file holds no cases");
            errors++;
        end
    endtask

    task automatic run_case(input int idx);
        spi_cmd_t  c;
        spi_data_t held;
        int        gap;
        int        extra;
        int        bits;
        c         = case_cmd[idx];
        bits      = word_bits(c.len);
        case_errs = 0;
        gap       = int'($unsigned($random(seed)) % 8);
        extra     = int'($unsigned($random(seed)) % 4);
        repeat (gap) @(negedge gclk);
        cmd   = c;
        reply = case_reply[idx];
        req   = 1'b1;
        @(negedge gclk);
        while (!ack) @(negedge gclk);
        expect_flag("cs_n at ack rise", cs_n, 1'b1);
        expect_flag("sck idle level with cs high", sck, c.mode[1]);
        compare_word("rx_data", rx_data, case_rx[idx]);
        compare_word("word seen on mosi", slave_mosi, case_mosi[idx]);
        verify_count("cs fall to first sck", slave_setup, at_least_one(c.setup));
        verify_count("last sck to cs rise", slave_hold, at_least_one(c.hold));
        verify_count("sck half-period", spi_delay_t'(slave_half),
                     spi_delay_t'(half_cycles(c.rate)));
        verify_count("sck toggles", slave_toggles, spi_delay_t'(2 * bits));
        expect_flag("uneven sck half-period", slave_half_err, 1'b0);
        // ack and data hold while the host keeps req up
        held = rx_data;
        repeat (extra) begin
            @(negedge gclk);
            expect_flag("ack while req held", ack, 1'b1);
            compare_word("rx_data while ack held", rx_data, held);
        end
        req = 1'b0;
        @(negedge gclk);
        expect_flag("ack before req is seen low", ack, 1'b1);
        expect_flag("cs_n while ack high", cs_n, 1'b1);
        @(negedge gclk);
        expect_flag("ack after req is seen low", ack, 1'b0);
        expect_flag("cs_n until ack low", cs_n, 1'b1);
        if (case_errs == 0) begin
            passed++;
            $display("case %0d passed: mode %0d, %0d bits", idx, c.mode, bits);
        end else begin
            failed++;
            $display("case %0d failed with %0d errors", idx, case_errs);
        end
    endtask

    initial begin
        seed      = 32'h6a85_487e;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        n_cases   = 0;
        cyc_cnt   = 0;
        cyc_limit = 0;
        timer_on  = 1'b0;
        nrst      = 1'b0;
        req       = 1'b0;
        cmd       = '0;
        reply     = '0;
        read_cases();
        for (k = 0; k < n_cases; k++) begin
            cyc_limit += 2 * word_bits(case_cmd[k].len) * half_cycles(case_cmd[k].rate)
                         + int'(case_cmd[k].setup) + int'(case_cmd[k].hold) + 40;
        end
        repeat (16) @(negedge gclk);
        nrst     = 1'b1;
        timer_on = 1'b1;
        for (k = 0; k < n_cases; k++) begin
            run_case(k);
        end
        $display("cases %0d, passed %0d, failed %0d, errors %0d",
                 n_cases, passed, failed, errors);
        if (errors == 0 && n_cases > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verif/spi_cases.txt
// hex columns: mode rate len setup hold tx reply expected_rx expected_mosi
// len 0..3 is 32, 16, 8, 4 bits; rate 0..3 is 1/128, 1/64, 1/32, 1/16
0 3 0 04 03 a5c31e7f 3c5a9600 3c5a9600 a5c31e7f
1 2 0 01 01 12345678 fedcba98 fedcba98 12345678
2 1 0 00 00 80000001 7ffffffe 7ffffffe 80000001
3 0 0 02 05 deadbeef 0badf00d 0badf00d deadbeef
0 0 1 03 02 cafe1234 9abc5678 00005678 00001234
1 3 1 00 01 0000ffff ffff8001 00008001 0000ffff
2 2 1 05 00 1357a5a5 2468c3c3 0000c3c3 0000a5a5
3 1 1 01 03 ffff0000 0000ffff 0000ffff 00000000
0 1 2 02 02 000000c6 0000003b 0000003b 000000c6
1 0 2 01 04 abcdef81 12345618 00000018 00000081
2 3 2 06 01 0000007e 000000e7 000000e7 0000007e
3 2 2 00 02 55555555 aaaaaaaa 000000aa 00000055
0 2 3 01 01 00000009 00000006 00000006 00000009
1 1 3 03 00 fffffffa 00000005 00000005 0000000a
2 0 3 02 02 0000000c 12345673 00000003 0000000c
3 3 3 01 06 87654321 0000000e 0000000e 00000001

//--- list.f
+incdir+rtl
rtl/spi_pkg.sv
rtl/spi_req_port.sv
rtl/spi_sck_gen.sv
rtl/spi_sequencer.sv
rtl/spi_shifter.sv
rtl/spi_master_top.sv
verif/spi_slave_model.sv
verif/tb_spi_master.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Mdir obj_dir
TOP   = tb_spi_master
FLIST = list.f
LOG   = sim.log
PASS  = Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(PASS)" $(LOG); then echo "test passed"; \
	else echo "test failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
